// File: hw/jtexterm_pkg.sv
// ##############################################
// Shared sizes, map geometry and the VRAM word
// views of the tile-map layer. Referenced by scope.
// ##############################################

package jtexterm_pkg;

    // VRAM is 4096 words of 16 bits, 8 KB seen from the CPU.
    localparam int vram_aw     = 12;      // Word address width.

    // Tile map geometry, 8x8 pixel tiles.
    localparam int map_cols    = 32;      // Tiles per map row.
    localparam int map_rows    = 32;      // Tile rows, map fills words 0 to 1023.

    // Row buffer between the scanner and the shifter.
    localparam int row_credits = 4;       // Buffer depth and initial credits.

    // One map entry as the scanner sees it.
    typedef struct packed {
        logic [8:0] code;                 // Tile code, selects 8 ROM words.
        logic       hflip;                // Mirror the pixels of the tile.
        logic [5:0] pal;                  // Palette, upper bits of col_addr.
    } tile_entry_t;

    // One VRAM word. The CPU works on bytes, the scanner on map entries.
    // Byte 0 holds the even CPU address.
    typedef union packed {
        tile_entry_t       tile;          // Scanner view.
        logic [1:0][7:0]   bytes;         // CPU view.
    } vram_word_u;

endpackage

// File: hw/jtexterm_vram_if.sv
// ##############################################
// Link between one VRAM client and the arbiter.
// Request is held until gnt, reads return a cycle later.
// ##############################################

`timescale 1ns/1ps

interface jtexterm_vram_if;

    // Client side.
    logic                               req;    // Held high until gnt.
    logic                               we;     // High for a write.
    logic [jtexterm_pkg::vram_aw-1:0]   addr;   // Word address.
    jtexterm_pkg::vram_word_u           wdata;  // Write data.
    logic [1:0]                         be;     // Byte enables, bit 0 is the even byte.

    // Arbiter side.
    logic                               gnt;    // One-cycle grant, write lands here.
    jtexterm_pkg::vram_word_u           rdata;  // Valid together with rvalid.
    logic                               rvalid; // One cycle after a read grant.

    modport client(output req, we, addr, wdata, be, input gnt, rdata, rvalid);
    modport arb   (input  req, we, addr, wdata, be, output gnt, rdata, rvalid);

endinterface

// File: hw/jtexterm_row_if.sv
// ##############################################
// Tile rows from the scanner to the pixel shifter.
// Every valid spends a credit, every retired row returns one.
// ##############################################

`timescale 1ns/1ps

interface jtexterm_row_if;

    // Scanner side.
    logic        valid;     // One cycle per row, only with a credit held.
    logic [31:0] row;       // Eight 4-bit pixels, nibble k at bits 4k+3:4k.
    logic [ 5:0] pal;       // Palette of the tile.
    logic        hflip;     // Pixels come out in reversed order.

    // Shifter side.
    logic        credit;    // One-cycle pulse per retired row.

    modport src(output valid, row, pal, hflip, input credit);
    modport dst(input valid, row, pal, hflip, output credit);

endinterface

// File: hw/jtexterm_vram_arb.sv
// ##############################################
// Single-port VRAM shared by the CPU and the scanner.
// Round-robin grants, byte writes, registered reads.
// ##############################################

`timescale 1ns/1ps

module jtexterm_vram_arb(
    input                   clk,
    input                   reset,
    jtexterm_vram_if.arb    cpu,
    jtexterm_vram_if.arb    scan
);

    logic [15:0]                        mem [0:(1 << jtexterm_pkg::vram_aw)-1];
    logic                               last_cpu;       // CPU won the last grant.
    logic                               cpu_gnt;
    logic                               scan_gnt;
    logic                               sel_we;
    logic [jtexterm_pkg::vram_aw-1:0]   sel_addr;
    jtexterm_pkg::vram_word_u           sel_wdata;
    logic [1:0]                         sel_be;
    jtexterm_pkg::vram_word_u           rd_q;           // Read port register.

    // A lone request always wins. On a tie the client that lost last time goes.
    always_comb begin
        cpu_gnt  = cpu.req & (~scan.req | ~last_cpu);
        scan_gnt = scan.req & ~cpu_gnt;
    end

    // Memory port follows the granted client, the CPU when idle.
    always_comb begin
        if (scan_gnt) begin
            sel_we    = scan.we;
            sel_addr  = scan.addr;
            sel_wdata = scan.wdata;
            sel_be    = scan.be;
        end else begin
            sel_we    = cpu.we;
            sel_addr  = cpu.addr;
            sel_wdata = cpu.wdata;
            sel_be    = cpu.be;
        end
    end

    always_ff @(posedge clk) begin
        if ((cpu_gnt | scan_gnt) && sel_we) begin
            if (sel_be[0]) mem[sel_addr][ 7:0] <= sel_wdata.bytes[0];
            if (sel_be[1]) mem[sel_addr][15:8] <= sel_wdata.bytes[1];
        end
        rd_q <= mem[sel_addr];                          // Read every cycle.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_cpu    <= 1'b0;
            cpu.rvalid  <= 1'b0;
            scan.rvalid <= 1'b0;
        end else begin
            if (cpu_gnt)       last_cpu <= 1'b1;
            else if (scan_gnt) last_cpu <= 1'b0;
            cpu.rvalid  <= cpu_gnt & ~cpu.we;           // Only the granted reader.
            scan.rvalid <= scan_gnt & ~scan.we;
        end
    end

    assign cpu.gnt    = cpu_gnt;
    assign scan.gnt   = scan_gnt;
    assign cpu.rdata  = rd_q;                           // Qualified by rvalid.
    assign scan.rdata = rd_q;

endmodule

// File: hw/jtexterm_cpu_port.sv
// ##############################################
// CPU byte bus to VRAM word requests. Holds the access
// until granted and answers with a cpu_ok pulse.
// ##############################################

`timescale 1ns/1ps

module jtexterm_cpu_port(
    input                       clk,
    input                       reset,
    input                       vram_cs,
    input                       cpu_rnw,
    input               [12:0]  cpu_addr,
    input               [ 7:0]  cpu_dout,
    output logic        [ 7:0]  cpu_din,
    output logic                cpu_ok,
    jtexterm_vram_if.client     bus
);

    logic cs_q, cs_qq;      // Chip select history.
    logic start;            // Rise of vram_cs.
    logic lane;             // Byte lane of the access.

    assign start = cs_q & ~cs_qq;

    always_ff @(posedge clk) begin
        if (reset) begin
            cs_q    <= 1'b0;
            cs_qq   <= 1'b0;
            bus.req <= 1'b0;
            cpu_ok  <= 1'b0;
        end else begin
            cs_q  <= vram_cs;
            cs_qq <= cs_q;
            if (start)        bus.req <= 1'b1;
            else if (bus.gnt) bus.req <= 1'b0;              // Grant is a single cycle.
            cpu_ok <= (bus.gnt & bus.we) | bus.rvalid;      // Write done or data back.
        end
    end

    // Access fields. The CPU keeps its inputs steady until cpu_ok.
    always_ff @(posedge clk) begin
        if (start) begin
            bus.we             <= ~cpu_rnw;
            bus.addr           <= cpu_addr[12:1];           // Word address.
            bus.wdata.bytes[0] <= cpu_dout;                 // Same byte on both lanes.
            bus.wdata.bytes[1] <= cpu_dout;
            bus.be             <= cpu_addr[0] ? 2'b10 : 2'b01;
            lane               <= cpu_addr[0];
        end
        if (bus.rvalid) cpu_din <= bus.rdata.bytes[lane];   // Pick the addressed byte.
    end

endmodule

// File: hw/jtexterm_tile_scan.sv
// ##############################################
// Line fetcher. Reads map entries from VRAM and rows
// from the graphics ROM, pushing rows against credits.
// ##############################################

`timescale 1ns/1ps

module jtexterm_tile_scan(
    input                       clk,
    input                       reset,
    input                       LHBL,
    input               [ 8:0]  vdump,
    input               [31:0]  rom_data,
    input                       rom_ok,
    output logic                rom_cs,
    output logic        [19:0]  rom_addr,
    jtexterm_vram_if.client     bus,
    jtexterm_row_if.src         rows
);

    logic                                           lhbl_l;
    logic [ 8:0]                                    vline;      // Line being fetched.
    logic [$clog2(jtexterm_pkg::map_cols):0]        rd_col;     // Next map column.
    logic                                           rd_wait;    // Read granted, data due.
    jtexterm_pkg::tile_entry_t                      ent;        // Entry waiting for ROM.
    logic                                           ent_valid;
    logic [ 5:0]                                    rom_pal;
    logic                                           rom_hflip;
    logic                                           row_full;   // Row waiting for a credit.
    logic [$clog2(jtexterm_pkg::row_credits):0]     credits;
    logic                                           line_start;
    logic                                           rd_issue;
    logic                                           rom_start;

    assign line_start = lhbl_l & ~LHBL;                         // Blanking starts.
    // One map read in flight, and only into an empty entry stage.
    assign rd_issue   = (rd_col < jtexterm_pkg::map_cols) & ~bus.req & ~rd_wait & ~ent_valid;
    assign rom_start  = ent_valid & ~rom_cs & ~row_full;

    assign rows.valid = row_full & (credits != 0);              // Back-pressure here.
    assign rows.pal   = rom_pal;                                // Steady while row_full.
    assign rows.hflip = rom_hflip;

    // The scanner only reads.
    assign bus.we    = 1'b0;
    assign bus.wdata = '0;
    assign bus.be    = 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_l    <= 1'b0;
            rd_col    <= $bits(rd_col)'(jtexterm_pkg::map_cols); // Idle.
            rd_wait   <= 1'b0;
            bus.req   <= 1'b0;
            ent_valid <= 1'b0;
            rom_cs    <= 1'b0;
            row_full  <= 1'b0;
            credits   <= $bits(credits)'(jtexterm_pkg::row_credits);
        end else begin
            lhbl_l <= LHBL;
            if (line_start) begin
                rd_col <= '0;                                   // Walk a new line.
            end else if (rd_issue) begin
                bus.req <= 1'b1;
            end else if (bus.gnt) begin
                bus.req <= 1'b0;
                rd_wait <= 1'b1;
                rd_col  <= rd_col + 1'b1;
            end
            if (bus.rvalid) rd_wait <= 1'b0;
            // Entry stage frees up as soon as its ROM fetch starts.
            if (bus.rvalid)     ent_valid <= 1'b1;
            else if (rom_start) ent_valid <= 1'b0;
            if (rom_start) rom_cs <= 1'b1;
            else if (rom_ok) rom_cs <= 1'b0;
            if (rom_cs && rom_ok) row_full <= 1'b1;
            else if (rows.valid)  row_full <= 1'b0;
            credits <= credits + rows.credit - rows.valid;      // Spend and refund.
        end
    end

    // Fetch fields, no reset needed on data.
    always_ff @(posedge clk) begin
        if (line_start) vline <= vdump;                         // Next line to show.
        if (rd_issue) begin
            bus.addr <= jtexterm_pkg::vram_aw'(
                (vline[8:3] % jtexterm_pkg::map_rows) * jtexterm_pkg::map_cols + rd_col);
        end
        if (bus.rvalid) ent <= bus.rdata.tile;                  // Tile view of the word.
        if (rom_start) begin
            rom_addr  <= {8'd0, ent.code, vline[2:0]};          // code*8 + row in tile.
            rom_pal   <= ent.pal;
            rom_hflip <= ent.hflip;
        end
        if (rom_cs && rom_ok) rows.row <= rom_data;
    end

endmodule

// File: hw/jtexterm_pxl_shift.sv
// ##############################################
// Row buffer and pixel shifter. One nibble per active
// pxl_cen becomes col_addr, finished rows return credits.
// ##############################################

`timescale 1ns/1ps

module jtexterm_pxl_shift(
    input                   clk,
    input                   reset,
    input                   pxl_cen,
    input                   LHBL,
    jtexterm_row_if.dst     rows,
    output logic    [9:0]   col_addr
);

    logic [31:0]                                    row_mem  [0:jtexterm_pkg::row_credits-1];
    logic [ 5:0]                                    pal_mem  [0:jtexterm_pkg::row_credits-1];
    logic                                           flip_mem [0:jtexterm_pkg::row_credits-1];
    logic [$clog2(jtexterm_pkg::row_credits)-1:0]   wr_ptr;
    logic [$clog2(jtexterm_pkg::row_credits)-1:0]   rd_ptr;     // Row on screen.
    logic [ 2:0]                                    pix;        // Pixel within the row.
    logic [ 2:0]                                    nib_idx;
    logic [31:0]                                    head_row;

    assign head_row = row_mem[rd_ptr];
    assign nib_idx  = flip_mem[rd_ptr] ? ~pix : pix;            // 7-pix when mirrored.

    // Buffer storage. Credits keep it from overflowing.
    always_ff @(posedge clk) begin
        if (rows.valid) begin
            row_mem[wr_ptr]  <= rows.row;
            pal_mem[wr_ptr]  <= rows.pal;
            flip_mem[wr_ptr] <= rows.hflip;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            pix         <= '0;
            col_addr    <= '0;
            rows.credit <= 1'b0;
        end else begin
            rows.credit <= 1'b0;
            if (rows.valid) wr_ptr <= wr_ptr + 1'b1;
            if (!LHBL) begin
                pix <= '0;                                      // Line restarts at pixel 0.
            end else if (pxl_cen) begin
                col_addr <= {pal_mem[rd_ptr], head_row[{nib_idx, 2'b00} +: 4]};
                pix      <= pix + 1'b1;
                if (pix == 3'd7) begin                          // Last pixel of the tile.
                    rd_ptr      <= rd_ptr + 1'b1;
                    rows.credit <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/jtexterm_gfx.sv
// ##############################################
// Tile-map layer top. CPU port and scanner share the
// VRAM through the arbiter, the shifter drives col_addr.
// ##############################################

`timescale 1ns/1ps

module jtexterm_gfx(
    input               clk,
    input               reset,

    input               pxl_cen,
    input               LHBL,
    input       [ 8:0]  vdump,
    input       [ 8:0]  hdump,      // Horizontal count, not needed by this layer.

    // CPU bus.
    input               vram_cs,
    input               cpu_rnw,
    input       [12:0]  cpu_addr,
    input       [ 7:0]  cpu_dout,
    output      [ 7:0]  cpu_din,
    output              cpu_ok,

    // Graphics ROM.
    output              rom_cs,
    output      [19:0]  rom_addr,
    input       [31:0]  rom_data,
    input               rom_ok,

    output      [ 9:0]  col_addr
);

    jtexterm_vram_if cpu_bus();     // CPU port to arbiter.
    jtexterm_vram_if scan_bus();    // Scanner to arbiter.
    jtexterm_row_if  row_bus();     // Scanner to shifter.

    jtexterm_cpu_port u_cpu(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .vram_cs  ( vram_cs  ),
        .cpu_rnw  ( cpu_rnw  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_din  ( cpu_din  ),
        .cpu_ok   ( cpu_ok   ),
        .bus      ( cpu_bus  )
    );

    jtexterm_vram_arb u_arb(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cpu      ( cpu_bus  ),
        .scan     ( scan_bus )
    );

    jtexterm_tile_scan u_scan(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .LHBL     ( LHBL     ),
        .vdump    ( vdump    ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .bus      ( scan_bus ),
        .rows     ( row_bus  )
    );

    jtexterm_pxl_shift u_shift(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .LHBL     ( LHBL     ),
        .rows     ( row_bus  ),
        .col_addr ( col_addr )
    );

endmodule

// File: tests/jtexterm_gfx_properties.sv
// ##############################################
// Protocol checks on the tile-map layer, bound into
// the top level. Each rule is a concurrent assertion.
// ##############################################

`timescale 1ns/1ps

module jtexterm_gfx_properties(
    input           clk,
    input           reset,
    input           rom_cs,
    input           rom_ok,
    input   [19:0]  rom_addr,
    input           row_valid,
    input   [ 2:0]  credits,        // Scanner credit count.
    input           cpu_gnt,
    input           scan_gnt,
    input           cpu_ok
);

    int fail_cnt;                   // Assertion failures so far.

    // ROM address held while the fetch is pending.
    rom_addr_held: assert property (@(posedge clk) disable iff (reset)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else begin
            fail_cnt++;
            $error("rom_addr changed during a pending ROM fetch");
        end

    // A row is only pushed against a held credit.
    row_needs_credit: assert property (@(posedge clk) disable iff (reset)
        !(row_valid && credits == 3'd0))
        else begin
            fail_cnt++;
            $error("row valid raised with no credit left");
        end

    grant_one_client: assert property (@(posedge clk) disable iff (reset)
        !(cpu_gnt && scan_gnt))
        else begin
            fail_cnt++;
            $error("VRAM granted to both clients in one cycle");
        end

    cpu_ok_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_ok |=> !cpu_ok)
        else begin
            fail_cnt++;
            $error("cpu_ok held longer than one cycle");
        end

endmodule

bind jtexterm_gfx jtexterm_gfx_properties props_i(
    .clk       ( clk             ),
    .reset     ( reset           ),
    .rom_cs    ( rom_cs          ),
    .rom_ok    ( rom_ok          ),
    .rom_addr  ( rom_addr        ),
    .row_valid ( row_bus.valid   ),
    .credits   ( u_scan.credits  ),
    .cpu_gnt   ( cpu_bus.gnt     ),
    .scan_gnt  ( scan_bus.gnt    ),
    .cpu_ok    ( cpu_ok          )
);

// File: tests/jtexterm_gfx_tb.sv
// ##############################################
// Testbench for the tile-map layer. Drives CPU traffic and
// video timing, models the ROM and checks every pixel.
// ##############################################

`timescale 1ns/1ps

module jtexterm_gfx_tb;

    localparam int line_cycles = 384 * 4;      // 256 active + 128 blank pixels.
    localparam int n_rand      = 200;          // Random CPU writes in the first phase.
    localparam int max_cycles  = 12 * line_cycles + (2048 + 2 * n_rand) * 10 + 2000;

    logic clk, reset, pxl_cen, LHBL, vram_cs, cpu_rnw, rom_ok, rom_cs, cpu_ok;
    logic [ 8:0] vdump, hdump;
    logic [12:0] cpu_addr;
    logic [ 7:0] cpu_dout, cpu_din;
    logic [19:0] rom_addr;
    logic [31:0] rom_data;
    logic [ 9:0] col_addr, exp_col;
    logic [15:0] map_mirror  [0:1023];          // Map words as written by the CPU.
    logic [ 7:0] byte_mirror [0:8191];
    bit          byte_set    [0:8191];          // Byte has been written.
    int          pix_n, cycles, pix_errs, cpu_errs, other_errs;
    bit          chk, video_done;

    jtexterm_gfx jtexterm_gfx_i(.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Graphics ROM contents. Every address bit is mixed in.
    function automatic logic [31:0] rom_hash(input logic [19:0] a);
        logic [31:0] h;
        h = {12'd0, a} * 32'h9e37_79b1;
        return h ^ (h >> 13) ^ {a, 12'h5a3};
    endfunction

    // Expected col_addr of pixel n on line v.
    function automatic logic [9:0] ref_pixel(input int v, input int n);
        logic [15:0] ent;
        logic [31:0] word;
        int          nib;
        ent  = map_mirror[((v / 8) % 32) * 32 + n / 8];
        word = rom_hash(20'(ent[15:7] * 8 + v % 8));   // Code times 8 plus row.
        nib  = ent[6] ? 7 - n % 8 : n % 8;              // hflip reverses.
        return {ent[5:0], word[4 * nib +: 4]};
    endfunction

    // ROM answers after 1 to 4 cycles. Data is junk outside rom_ok.
    initial begin
        int lat;
        rom_ok   = 1'b0;
        rom_data = '0;
        forever begin
            @(negedge clk);
            if (rom_cs && !reset) begin
                lat = $urandom_range(1, 4);
                repeat (lat - 1) @(negedge clk);
                rom_data = rom_hash(rom_addr);
                rom_ok   = 1'b1;
                @(negedge clk);
                rom_ok   = 1'b0;
                rom_data = $urandom;
            end
        end
    end

    // Register the expected pixel at each active pxl_cen.
    always @(posedge clk) begin
        if (reset || !LHBL) begin
            pix_n <= 0;
            chk   <= 1'b0;
        end else begin
            chk <= pxl_cen;
            if (pxl_cen) begin
                exp_col <= ref_pixel(vdump, pix_n);
                pix_n   <= pix_n + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (chk) begin
            assert (col_addr === exp_col) else begin
                pix_errs++;
                $display("error: col_addr = %h, expected %h (vdump %h, pixel %h)",
                         col_addr, exp_col, vdump, pix_n - 1);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles, the DUT stopped making progress", cycles);
            $display("test failed");
            $finish;
        end
    end

    // One CPU access held until cpu_ok.
    task automatic cpu_access(input logic rnw, input logic [12:0] a, input logic [7:0] d,
                              output logic [7:0] din);
        int waited;
        waited = 0;
        @(negedge clk);
        vram_cs  = 1'b1;
        cpu_rnw  = rnw;
        cpu_addr = a;
        cpu_dout = d;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpu_ok && waited < 200);
        assert (cpu_ok) else begin
            other_errs++;
            $display("CPU access to %h never got cpu_ok", a);
        end
        din     = cpu_din;                              // Valid in the cpu_ok cycle.
        vram_cs = 1'b0;
    endtask

    task automatic cpu_write(input logic [12:0] a, input logic [7:0] d);
        logic [7:0] unused;
        cpu_access(1'b0, a, d, unused);
        byte_mirror[a] = d;
        byte_set[a]    = 1'b1;
    endtask

    task automatic cpu_read_check(input logic [12:0] a);
        logic [7:0] d;
        cpu_access(1'b1, a, 8'h00, d);
        assert (d === byte_mirror[a]) else begin
            cpu_errs++;
            $display("error: cpu_din = %h, expected %h at cpu_addr %h", d, byte_mirror[a], a);
        end
    endtask

    // Random traffic above the map area.
    task automatic cpu_random();
        logic [12:0] a;
        a = 13'h1000 + 13'($urandom_range(0, 127));
        if ($urandom_range(0, 1) && byte_set[a]) cpu_read_check(a);
        else cpu_write(a, 8'($urandom));
    endtask

    // Whole lines with blanking first. vdump moves at the LHBL fall.
    task automatic video_lines(input int first, input int count);
        for (int l = 0; l < count; l++) begin
            LHBL  = 1'b0;
            vdump = 9'(first + l);
            for (int p = 0; p < 384; p++) begin
                if (p == 128) LHBL = 1'b1;              // Active part of the line.
                hdump = 9'(p);
                @(negedge clk) pxl_cen = 1'b1;
                @(negedge clk) pxl_cen = 1'b0;
                repeat (2) @(negedge clk);
            end
        end
    endtask

    initial begin
        logic [15:0] val;
        int unsigned seed;
        int          prop_errs;
        seed = $urandom(54394);
        reset = 1'b1;
        pxl_cen = 1'b0;
        LHBL = 1'b1;                                    // No fetch until the first fall.
        vdump = '0;
        hdump = '0;
        vram_cs = 1'b0;
        cpu_rnw = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!cpu_ok && !rom_cs && col_addr == 10'd0) else begin
            other_errs++;
            $display("outputs not idle after reset");
        end
        for (int i = 0; i < n_rand; i++) cpu_write(13'h1000 + 13'($urandom_range(0, 127)),
                                                 8'($urandom));
        for (int i = 0; i < 128; i++) if (byte_set[13'h1000 + i]) cpu_read_check(13'h1000 + i);
        for (int w = 0; w < 1024; w++) begin            // Random map. Byte 0 is the even one.
            val = $urandom;
            map_mirror[w] = val;
            cpu_write(13'(2 * w), val[7:0]);
            cpu_write(13'(2 * w + 1), val[15:8]);
        end
        video_lines(60, 8);                             // Crosses a tile row boundary.
        fork
            begin
                video_lines(68, 4);
                video_done = 1'b1;
            end
            while (!video_done) cpu_random();           // CPU contends with the scanner.
        join
        prop_errs = jtexterm_gfx_i.props_i.fail_cnt;    // Failed protocol assertions.
        $display("errors: %0d pixel, %0d cpu data, %0d other, %0d protocol",
                 pix_errs, cpu_errs, other_errs, prop_errs);
        if (pix_errs + cpu_errs + other_errs + prop_errs == 0) $display("test passed");
        else $display("test failed");
        $finish;
    end

endmodule

// File: all.f
hw/jtexterm_pkg.sv
hw/jtexterm_vram_if.sv
hw/jtexterm_row_if.sv
hw/jtexterm_vram_arb.sv
hw/jtexterm_cpu_port.sv
hw/jtexterm_tile_scan.sv
hw/jtexterm_pxl_shift.sv
hw/jtexterm_gfx.sv
tests/jtexterm_gfx_properties.sv
tests/jtexterm_gfx_tb.sv
